//--- files.f
+incdir+rtl
rtl/vga_pkg.sv
rtl/vga_if.sv
rtl/vga_timing.sv
rtl/vram_fetch.sv
rtl/frame_vram.sv
rtl/pixel_serializer.sv
rtl/vga_display_top.sv
tests/tb_clock.sv
tests/vga_display_props.sv
tests/vga_display_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the VGA display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f files.f --top-module vga_display_tb -o vga_display_sim

out=$(./obj_dir/vga_display_sim +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1

//--- tests/vga_display_tb.sv
// VGA display testbench
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_display_tb;

   localparam int LINE_CYCLES  = `H_DISP + `H_FPORCH + `H_SYNC + `H_BPORCH;
   localparam int FRAME_LINES  = `V_DISP + `V_FPORCH + `V_SYNC + `V_BPORCH;
   localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
   localparam int BOX_WORDS    = (`BOX_WIDTH / 32) * `BOX_HEIGHT;
   localparam int BOX_H_END    = `BOX_H_OFFSET + `BOX_WIDTH;
   localparam int BOX_V_END    = `BOX_V_OFFSET + `BOX_HEIGHT;
   // Frame 5 active area ends near 23.6k cycles, a little slack past it
   localparam int TIMEOUT_CYCLES = 24000;

   localparam int T_HSYNC   = 0;
   localparam int T_VSYNC   = 1;
   localparam int T_BLANK   = 2;
   localparam int T_BORDER  = 3;
   localparam int T_BOX2    = 4;
   localparam int T_BLACK   = 5;
   localparam int T_BOX5    = 6;
   localparam int T_RGB     = 7;
   localparam int NUM_TESTS = 8;

   logic                vga_clk;
   logic                reset;
   logic                host_we;
   vga_pkg::vram_addr_t host_addr;
   vga_pkg::vram_word_t host_wdata;
   logic                vga_r;
   logic                vga_g;
   logic                vga_b;
   logic                vga_hsync;
   logic                vga_vsync;
   logic                vga_blank;

   vga_pkg::vram_word_t model [BOX_WORDS];
   logic [31:0]         rng_state;
   string               test_names [NUM_TESTS];
   int                  checks [NUM_TESTS];
   int                  errors [NUM_TESTS];
   int                  tests_failed;
   int                  assert_fails;
   int                  cycles;

   // Screen position recovered from the sync outputs
   int   col;
   int   row;
   int   frame;
   int   sample_n;
   int   hs_rise_at;
   int   vs_rise_at;
   logic hs_q;
   logic vs_q;
   bit   h_locked;
   bit   v_locked;
   bit   frame2_done;
   bit   frame5_done;

   tb_clock clk0 (
      .vga_clk (vga_clk),
      .reset   (reset)
   );

   vga_display_top dut0 (
      .vga_clk    (vga_clk),
      .reset      (reset),
      .host_we    (host_we),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .vga_r      (vga_r),
      .vga_g      (vga_g),
      .vga_b      (vga_b),
      .vga_hsync  (vga_hsync),
      .vga_vsync  (vga_vsync),
      .vga_blank  (vga_blank)
   );

   bind vram_fetch vga_display_props props_fetch (
      .vga_clk     (vga_clk),
      .reset       (reset),
      .count       (credits),
      .req         (rd.req),
      .credit      (rd.credit),
      .fill        ('0),
      .rdata_valid (1'b0),
      .color       (3'b000),
      .blank       (1'b0)
   );

   bind pixel_serializer vga_display_props props_ser (
      .vga_clk     (vga_clk),
      .reset       (reset),
      .count       (fifo_count),
      .req         (1'b0),
      .credit      (1'b0),
      .fill        (fifo_count),
      .rdata_valid (rd.rdata_valid),
      .color       ({vga_r, vga_g, vga_b}),
      .blank       (vga_blank)
   );

   ////////////////////////////////////////
   // Stimulus and model

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // One word per cycle over the host port
   task automatic write_random_words();
      for (int i = 0; i < BOX_WORDS; i++) begin
         rng_state = xorshift32(rng_state);
         model[i] = rng_state;
         @(posedge vga_clk);
         #1;
         host_we    = 1'b1;
         host_addr  = vga_pkg::vram_addr_t'(i);
         host_wdata = rng_state;
      end
      @(posedge vga_clk);
      #1;
      host_we = 1'b0;
   endtask

   function automatic bit on_border(input int r, input int c);
      bit v_edge;
      bit h_edge;
      h_edge = (c == `BOX_H_OFFSET - 1) || (c == BOX_H_END);
      v_edge = (r == `BOX_V_OFFSET - 1) || (r == BOX_V_END);
      return (h_edge && r >= `BOX_V_OFFSET - 1 && r <= BOX_V_END) ||
             (v_edge && c >= `BOX_H_OFFSET - 1 && c <= BOX_H_END);
   endfunction

   function automatic bit in_box(input int r, input int c);
      return c >= `BOX_H_OFFSET && c < BOX_H_END && r >= `BOX_V_OFFSET && r < BOX_V_END;
   endfunction

   // Bit 0 of each word is the leftmost pixel
   function automatic logic box_pixel(input int r, input int c);
      int word_idx;
      int bit_idx;
      word_idx = (r - `BOX_V_OFFSET) * (`BOX_WIDTH / 32) + (c - `BOX_H_OFFSET) / 32;
      bit_idx  = (c - `BOX_H_OFFSET) % 32;
      return model[word_idx][bit_idx];
   endfunction

   ////////////////////////////////////////
   // Checking

   task automatic compare(input int test_id, input logic [31:0] expected,
                          input logic [31:0] actual);
      checks[test_id]++;
      if (actual !== expected) begin
         errors[test_id]++;
         $display("Fail %s: expected %0h, actual %0h (frame %0d row %0d col %0d)",
                  test_names[test_id], expected, actual, frame, row, col);
      end
   endtask

   task automatic report_test(input int test_id);
      if (checks[test_id] == 0) begin
         tests_failed++;
         $display("%s: failed, nothing was checked", test_names[test_id]);
      end else if (errors[test_id] != 0) begin
         tests_failed++;
         $display("%s: failed, %0d of %0d checks wrong", test_names[test_id],
                  errors[test_id], checks[test_id]);
      end else begin
         $display("%s: passed, %0d checks", test_names[test_id], checks[test_id]);
      end
   endtask

   // Falling hsync is column -H_BPORCH, falling vsync is row -V_BPORCH
   task automatic track_position();
      if (hs_q && !vga_hsync) begin
         col = -`H_BPORCH;
         h_locked = 1'b1;
      end else begin
         col++;
         if (col == 0)
            row++;
      end
      if (vs_q && !vga_vsync) begin
         row = -`V_BPORCH;
         frame++;
         v_locked = 1'b1;
         if (frame == 3)
            frame2_done = 1'b1;
      end
      if (frame == 5 && row == `V_DISP && col == 0)
         frame5_done = 1'b1;
   endtask

   task automatic measure_sync();
      if (!hs_q && vga_hsync) begin
         if (hs_rise_at >= 0)
            compare(T_HSYNC, LINE_CYCLES, sample_n - hs_rise_at);
         hs_rise_at = sample_n;
      end
      if (hs_q && !vga_hsync && hs_rise_at >= 0)
         compare(T_HSYNC, `H_SYNC, sample_n - hs_rise_at);
      if (!vs_q && vga_vsync) begin
         if (vs_rise_at >= 0)
            compare(T_VSYNC, FRAME_CYCLES, sample_n - vs_rise_at);
         vs_rise_at = sample_n;
      end
      if (vs_q && !vga_vsync && vs_rise_at >= 0)
         compare(T_VSYNC, `V_SYNC * LINE_CYCLES, sample_n - vs_rise_at);
   endtask

   task automatic check_pixel();
      logic [2:0] rgb;
      logic       exp_blank;
      rgb = {vga_r, vga_g, vga_b};
      // Monochrome, so the three guns are all off or all on
      compare(T_RGB, 1'b1, (rgb == 3'b000) || (rgb == 3'b111));
      exp_blank = !(col >= 0 && col < `H_DISP && row >= 0 && row < `V_DISP);
      if (frame == 2) begin
         compare(T_BLANK, exp_blank, vga_blank);
         if (exp_blank)
            compare(T_BLANK, 3'b000, rgb);
         else if (on_border(row, col))
            compare(T_BORDER, 3'b111, rgb);
         else if (in_box(row, col))
            compare(T_BOX2, box_pixel(row, col), vga_r);
         else
            compare(T_BLACK, 3'b000, rgb);
      end else if (frame == 5 && !exp_blank && in_box(row, col)) begin
         compare(T_BOX5, box_pixel(row, col), vga_r);
      end
   endtask

   // Outputs settle after the rising edge, sampled on the falling one
   always @(negedge vga_clk) begin
      if (!reset) begin
         sample_n++;
         track_position();
         measure_sync();
         if (h_locked && v_locked)
            check_pixel();
         hs_q = vga_hsync;
         vs_q = vga_vsync;
      end
   end

   ////////////////////////////////////////
   // Main sequence

   initial begin
      host_we      = 1'b0;
      host_addr    = '0;
      host_wdata   = '0;
      rng_state    = 32'h2b5dfdab;
      hs_q         = 1'b0;
      vs_q         = 1'b0;
      col          = 0;
      row          = 0;
      frame        = 0;
      sample_n     = 0;
      hs_rise_at   = -1;
      vs_rise_at   = -1;
      h_locked     = 1'b0;
      v_locked     = 1'b0;
      frame2_done  = 1'b0;
      frame5_done  = 1'b0;
      tests_failed = 0;
      test_names[T_HSYNC]  = "hsync_timing";
      test_names[T_VSYNC]  = "vsync_timing";
      test_names[T_BLANK]  = "blank_area";
      test_names[T_BORDER] = "border_white";
      test_names[T_BOX2]   = "box_pixels_f2";
      test_names[T_BLACK]  = "outside_black";
      test_names[T_BOX5]   = "box_pixels_f5";
      test_names[T_RGB]    = "rgb_equal";
      for (int i = 0; i < NUM_TESTS; i++) begin
         checks[i] = 0;
         errors[i] = 0;
      end

      @(negedge reset);
      write_random_words();

      // Frame 2 shows the first fill
      wait (frame2_done);
      report_test(T_BLANK);
      report_test(T_BORDER);
      report_test(T_BOX2);
      report_test(T_BLACK);

      // New contents written during frame 3, shown from frame 5
      write_random_words();
      wait (frame5_done);
      report_test(T_BOX5);
      report_test(T_HSYNC);
      report_test(T_VSYNC);
      report_test(T_RGB);

      assert_fails = dut0.u_fetch.props_fetch.fail_count +
                     dut0.u_serializer.props_ser.fail_count;
      $display("Tests: %0d run, %0d failed, %0d assertion failures",
               NUM_TESTS, tests_failed, assert_fails);
      if (tests_failed == 0 && assert_fails == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge vga_clk);
         cycles++;
      end
      $display("Timeout: frame 5 was not fully shown within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
   end

endmodule

//--- tests/vga_display_props.sv
// Credit and output assertions
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_display_props (
   input logic             vga_clk,
   input logic             reset,
   input vga_pkg::credit_t count,
   input logic             req,
   input logic             credit,
   input vga_pkg::credit_t fill,
   input logic             rdata_valid,
   input logic [2:0]       color,
   input logic             blank
);

   int fail_count = 0;

   // Credits in use, rebuilt from the req and credit pulses alone
   int in_use;

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset)
         in_use <= 0;
      else
         in_use <= in_use + int'(req) - int'(credit);
   end

   ////////////////////////////////////////
   // Flow control

   credit_bound: assert property (@(posedge vga_clk) disable iff (reset)
      count <= vga_pkg::credit_t'(`FETCH_CREDITS))
   else begin
      fail_count++;
      $error("credit count above the FIFO depth");
   end

   // A read is only issued with a credit in hand
   req_needs_credit: assert property (@(posedge vga_clk) disable iff (reset)
      req |-> (in_use < `FETCH_CREDITS))
   else begin
      fail_count++;
      $error("read request issued with no credit left");
   end

   no_overflow: assert property (@(posedge vga_clk) disable iff (reset)
      rdata_valid |-> (fill < vga_pkg::credit_t'(`FETCH_CREDITS)))
   else begin
      fail_count++;
      $error("read data arrived while the word FIFO was full");
   end

   ////////////////////////////////////////
   // Video output

   dark_in_blank: assert property (@(posedge vga_clk) disable iff (reset)
      blank |-> (color == 3'b000))
   else begin
      fail_count++;
      $error("color driven during blanking");
   end

endmodule

//--- tests/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
   output logic vga_clk,
   output logic reset
);

   // 40 ns period
   initial begin
      vga_clk = 1'b0;
      forever #20 vga_clk = ~vga_clk;
   end

   // Held for two rising edges, released just after the second
   initial begin
      reset = 1'b1;
      repeat (2) @(posedge vga_clk);
      #1 reset = 1'b0;
   end

endmodule

//--- rtl/vga_display_top.sv
// VGA frame display top level
`timescale 1ns/1ps

module vga_display_top (
   input  logic                vga_clk,
   input  logic                reset,
   input  logic                host_we,
   input  vga_pkg::vram_addr_t host_addr,
   input  vga_pkg::vram_word_t host_wdata,
   output logic                vga_r,
   output logic                vga_g,
   output logic                vga_b,
   output logic                vga_hsync,
   output logic                vga_vsync,
   output logic                vga_blank
);

   scan_if    scan0 ();
   vram_rd_if rd0 ();

   ////////////////////////////////////////
   // Scan and fetch

   vga_timing u_timing (
      .vga_clk (vga_clk),
      .reset   (reset),
      .scan    (scan0)
   );

   vram_fetch u_fetch (
      .vga_clk (vga_clk),
      .reset   (reset),
      .scan    (scan0),
      .rd      (rd0)
   );

   frame_vram u_vram (
      .vga_clk    (vga_clk),
      .reset      (reset),
      .host_we    (host_we),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .rd         (rd0)
   );

   ////////////////////////////////////////
   // Pixel output

   pixel_serializer u_serializer (
      .vga_clk   (vga_clk),
      .reset     (reset),
      .scan      (scan0),
      .rd        (rd0),
      .vga_r     (vga_r),
      .vga_g     (vga_g),
      .vga_b     (vga_b),
      .vga_hsync (vga_hsync),
      .vga_vsync (vga_vsync),
      .vga_blank (vga_blank)
   );

endmodule

//--- rtl/pixel_serializer.sv
// Pixel serializer and color output
`timescale 1ns/1ps
`include "vga_config.svh"

module pixel_serializer (
   input logic           vga_clk,
   input logic           reset,
   scan_if.sink          scan,
   vram_rd_if.serializer rd,
   output logic          vga_r,
   output logic          vga_g,
   output logic          vga_b,
   output logic          vga_hsync,
   output logic          vga_vsync,
   output logic          vga_blank
);

   // Two entries, so one-bit pointers
   vga_pkg::vram_word_t fifo_mem [`FETCH_CREDITS];
   logic                wr_ptr;
   logic                rd_ptr;
   vga_pkg::credit_t    fifo_count;

   vga_pkg::vram_word_t head;
   vga_pkg::vram_word_t shift_q;
   logic                pop;
   logic                pixel;
   logic                color_q;

   assign head = fifo_mem[rd_ptr];
   assign pop  = scan.word_pop && (fifo_count != '0);

   ////////////////////////////////////////
   // Word FIFO

   always_ff @(posedge vga_clk) begin
      if (rd.rdata_valid)
         fifo_mem[wr_ptr] <= rd.rdata;
   end

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         wr_ptr     <= 1'b0;
         rd_ptr     <= 1'b0;
         fifo_count <= '0;
         rd.credit  <= 1'b0;
      end else begin
         if (rd.rdata_valid)
            wr_ptr <= ~wr_ptr;
         if (pop)
            rd_ptr <= ~rd_ptr;
         case ({rd.rdata_valid, pop})
            2'b10:   fifo_count <= fifo_count + 1'b1;
            2'b01:   fifo_count <= fifo_count - 1'b1;
            default: fifo_count <= fifo_count;
         endcase
         // Freed slot goes back to the fetcher
         rd.credit <= pop;
      end
   end

   ////////////////////////////////////////
   // Shift register and color

   // Bit 0 of a new word shows on the pop cycle itself
   always_ff @(posedge vga_clk) begin
      if (pop)
         shift_q <= {1'b0, head[31:1]};
      else if (scan.in_box)
         shift_q <= {1'b0, shift_q[31:1]};
   end

   always_comb begin
      if (scan.in_box)
         pixel = pop ? head[0] : shift_q[0];
      else
         pixel = scan.in_border;
   end

   // Sync and blank delayed to line up with the color
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         color_q   <= 1'b0;
         vga_hsync <= 1'b0;
         vga_vsync <= 1'b0;
         vga_blank <= 1'b1;
      end else begin
         color_q   <= pixel && !scan.blank;
         vga_hsync <= scan.hsync;
         vga_vsync <= scan.vsync;
         vga_blank <= scan.blank;
      end
   end

   // Monochrome, same level on all three guns
   assign vga_r = color_q;
   assign vga_g = color_q;
   assign vga_b = color_q;

endmodule

//--- rtl/frame_vram.sv
// Frame VRAM with host write port
`timescale 1ns/1ps
`include "vga_config.svh"

module frame_vram (
   input logic                vga_clk,
   input logic                reset,
   input logic                host_we,
   input vga_pkg::vram_addr_t host_addr,
   input vga_pkg::vram_word_t host_wdata,
   vram_rd_if.memory          rd
);

   vga_pkg::vram_word_t mem [`VRAM_WORDS];
   vga_pkg::vram_word_t rdata_s1;
   logic                valid_s1;

   // Host write
   always_ff @(posedge vga_clk) begin
      if (host_we)
         mem[host_addr] <= host_wdata;
   end

   ////////////////////////////////////////
   // Two-stage read pipeline

   always_ff @(posedge vga_clk) begin
      if (rd.req)
         rdata_s1 <= mem[rd.addr];
      rd.rdata <= rdata_s1;
   end

   // Valid travels alongside the data
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         valid_s1       <= 1'b0;
         rd.rdata_valid <= 1'b0;
      end else begin
         valid_s1       <= rd.req;
         rd.rdata_valid <= valid_s1;
      end
   end

endmodule

//--- rtl/vram_fetch.sv
// VRAM word fetcher
`timescale 1ns/1ps
`include "vga_config.svh"

module vram_fetch (
   input logic      vga_clk,
   input logic      reset,
   scan_if.sink     scan,
   vram_rd_if.fetch rd
);

   localparam int FRAME_WORDS = (`BOX_WIDTH / 32) * `BOX_HEIGHT;

   vga_pkg::credit_t   credits;
   vga_pkg::credit_t   credits_next;
   vga_pkg::vram_addr_t next_addr;
   logic               issue;

   ////////////////////////////////////////
   // Credit accounting

   // Credits for the next cycle, with this cycle's req and return applied
   always_comb begin
      credits_next = credits + vga_pkg::credit_t'(rd.credit)
                     - vga_pkg::credit_t'(rd.req);
      issue = (credits_next != '0) && (next_addr < FRAME_WORDS) && !scan.frame_start;
   end

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         credits <= vga_pkg::credit_t'(`FETCH_CREDITS);
         rd.req  <= 1'b0;
      end else begin
         credits <= credits_next;
         rd.req  <= issue;
      end
   end

   ////////////////////////////////////////
   // Sequential address

   // Also counts the words issued in this frame
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset)
         next_addr <= '0;
      else if (scan.frame_start)
         next_addr <= '0;
      else if (issue)
         next_addr <= next_addr + 1'b1;
   end

   always_ff @(posedge vga_clk) begin
      if (issue)
         rd.addr <= next_addr;
   end

endmodule

//--- rtl/vga_timing.sv
// VGA scan timing generator
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_timing (
   input logic    vga_clk,
   input logic    reset,
   scan_if.source scan
);

   localparam int H_TOTAL  = `H_DISP + `H_FPORCH + `H_SYNC + `H_BPORCH;
   localparam int V_TOTAL  = `V_DISP + `V_FPORCH + `V_SYNC + `V_BPORCH;
   localparam int HS_START = `H_DISP + `H_FPORCH;
   localparam int HS_END   = HS_START + `H_SYNC;
   localparam int VS_START = `V_DISP + `V_FPORCH;
   localparam int VS_END   = VS_START + `V_SYNC;

   // First column and row past the box
   localparam int BOX_H_END = `BOX_H_OFFSET + `BOX_WIDTH;
   localparam int BOX_V_END = `BOX_V_OFFSET + `BOX_HEIGHT;

   vga_pkg::coord_t h_cnt;
   vga_pkg::coord_t v_cnt;
   vga_pkg::coord_t h_rel;

   logic active;
   logic h_box;
   logic v_box;
   logic h_span;
   logic v_span;
   logic h_edge;
   logic v_edge;

   ////////////////////////////////////////
   // Line and frame counters

   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_cnt == vga_pkg::coord_t'(H_TOTAL - 1)) begin
         h_cnt <= '0;
         if (v_cnt == vga_pkg::coord_t'(V_TOTAL - 1))
            v_cnt <= '0;
         else
            v_cnt <= v_cnt + 1'b1;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // Position decode

   always_comb begin
      active = (h_cnt < `H_DISP) && (v_cnt < `V_DISP);
      h_box  = (h_cnt >= `BOX_H_OFFSET) && (h_cnt < BOX_H_END);
      v_box  = (v_cnt >= `BOX_V_OFFSET) && (v_cnt < BOX_V_END);
      // Border is one pixel outside the box on every side
      h_span = (h_cnt >= `BOX_H_OFFSET - 1) && (h_cnt <= BOX_H_END);
      v_span = (v_cnt >= `BOX_V_OFFSET - 1) && (v_cnt <= BOX_V_END);
      h_edge = (h_cnt == `BOX_H_OFFSET - 1) || (h_cnt == BOX_H_END);
      v_edge = (v_cnt == `BOX_V_OFFSET - 1) || (v_cnt == BOX_V_END);
      h_rel  = h_cnt - vga_pkg::coord_t'(`BOX_H_OFFSET);
   end

   // All flags registered together
   always_ff @(posedge vga_clk or posedge reset) begin
      if (reset) begin
         scan.hsync       <= 1'b0;
         scan.vsync       <= 1'b0;
         scan.blank       <= 1'b1;
         scan.in_box      <= 1'b0;
         scan.in_border   <= 1'b0;
         scan.word_pop    <= 1'b0;
         scan.frame_start <= 1'b0;
      end else begin
         scan.hsync       <= (h_cnt >= HS_START) && (h_cnt < HS_END);
         scan.vsync       <= (v_cnt >= VS_START) && (v_cnt < VS_END);
         scan.blank       <= !active;
         scan.in_box      <= active && h_box && v_box;
         scan.in_border   <= active && ((h_edge && v_span) || (v_edge && h_span));
         // New word at each 32-pixel boundary inside the box
         scan.word_pop    <= active && h_box && v_box && (h_rel[4:0] == 5'd0);
         scan.frame_start <= (v_cnt == vga_pkg::coord_t'(VS_START)) && (h_cnt == '0);
      end
   end

endmodule

//--- rtl/vga_if.sv
// Scan and VRAM read interfaces
`timescale 1ns/1ps

// Registered scan flags, all for one screen position
interface scan_if;
   logic hsync;
   logic vsync;
   logic blank;
   logic in_box;
   logic in_border;
   logic word_pop;
   logic frame_start;

   modport source (
      output hsync, vsync, blank, in_box, in_border, word_pop, frame_start
   );
   modport sink (
      input hsync, vsync, blank, in_box, in_border, word_pop, frame_start
   );
endinterface

// Word reads from the frame VRAM, with credits back to the fetcher
interface vram_rd_if;
   logic                 req;
   vga_pkg::vram_addr_t  addr;
   vga_pkg::vram_word_t  rdata;
   logic                 rdata_valid;
   logic                 credit;

   modport fetch (
      output req, addr,
      input  credit
   );
   modport memory (
      input  req, addr,
      output rdata, rdata_valid
   );
   modport serializer (
      input  rdata, rdata_valid,
      output credit
   );
endinterface

//--- rtl/vga_pkg.sv
// VGA display shared types

package vga_pkg;

   ////////////////////////////////////////
   // Scan position

   // Wide enough for any line or frame count
   typedef logic [10:0] coord_t;

   ////////////////////////////////////////
   // Frame memory

   // Word address into the frame VRAM
   typedef logic [5:0] vram_addr_t;

   // 32 pixels, bit 0 shown first
   typedef logic [31:0] vram_word_t;

   ////////////////////////////////////////
   // Flow control

   // Credits held by the fetcher, also the FIFO fill level
   typedef logic [1:0] credit_t;

endpackage

//--- rtl/vga_config.svh
// VGA display configuration
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// Horizontal timing, in pixel clocks
`define H_DISP    96
`define H_FPORCH  8
`define H_SYNC    12
`define H_BPORCH  12

// Vertical timing, in lines
`define V_DISP    24
`define V_FPORCH  2
`define V_SYNC    4
`define V_BPORCH  2

// Box placement in pixels, width a multiple of 32
`define BOX_H_OFFSET  16
`define BOX_WIDTH     64
`define BOX_V_OFFSET  4
`define BOX_HEIGHT    16

`define VRAM_WORDS     64
`define FETCH_CREDITS  2

`endif
